//--- logic/policer_pkg.sv
//////////////////////////////
// Ingress policer types
//////////////////////////////

package policer_pkg;

    // Port and descriptor widths
    localparam int NUM_PORTS = 11;
    localparam int PORT_W    = 4;
    localparam int BLEN_W    = 11;
    localparam int PRIO_W    = 3;

    // Fixed-point rate and bucket widths
    localparam int CIR_WHOLE_W   = 8;
    localparam int CIR_FRAC_W    = 8;
    localparam int CIR_W         = CIR_WHOLE_W + CIR_FRAC_W;
    localparam int CBS_W         = 24;
    localparam int LEVEL_W       = 32;
    localparam int LEVEL_FRAC_W  = CIR_FRAC_W;
    localparam int LEVEL_WHOLE_W = LEVEL_W - LEVEL_FRAC_W;

    // AXI4-Lite and register map
    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int TABLE_W    = 2;
    localparam int TABLE_LSB  = 8;
    localparam int PORT_LSB   = 2;

    // Output queue of the marker
    localparam int QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W = 1;
    localparam int QUEUE_CNT_W = 2;

    typedef enum logic [TABLE_W-1:0] {
        CIR_TABLE    = 2'd0,
        CBS_TABLE    = 2'd1,
        ENABLE_TABLE = 2'd2
    } cfg_table_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic [PORT_W-1:0] ingress_port;
        logic [PORT_W-1:0] egress_port;
        logic [PRIO_W-1:0] prio;
        logic [BLEN_W-1:0] byte_length;
    } pkt_desc_t;

    typedef struct packed {
        pkt_desc_t desc;
        logic      policer_drop_mark;
    } policed_desc_t;

    // Bytes drained per clock in 8.8 fixed point
    typedef struct packed {
        logic [CIR_WHOLE_W-1:0] whole;
        logic [CIR_FRAC_W-1:0]  fraction;
    } cir_t;

    typedef struct packed {
        cir_t             cir;
        logic [CBS_W-1:0] cbs;
        logic             enable;
    } bucket_cfg_t;

    typedef struct packed {
        logic                  awvalid;
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  wvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic [AXI_STRB_W-1:0] wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        axi_resp_e             bresp;
        logic                  arready;
        logic                  rvalid;
        logic [AXI_DATA_W-1:0] rdata;
        axi_resp_e             rresp;
    } axil_rsp_t;

endpackage

//--- logic/policer_cfg_regs.sv
//////////////////////////////
// Policer config registers
//////////////////////////////

`timescale 1ns/1ps

module policer_cfg_regs
    import policer_pkg::*;
(
    input  logic        core_clk_ifc,
    input  logic        timer_reset,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    output bucket_cfg_t port_cfg [NUM_PORTS]
);

    cfg_table_e            wr_table;
    cfg_table_e            rd_table;
    logic [PORT_W-1:0]     wr_port;
    logic [PORT_W-1:0]     rd_port;
    logic [PORT_W-1:0]     wr_idx;
    logic [PORT_W-1:0]     rd_idx;
    logic                  wr_hit;
    logic                  rd_hit;
    logic                  wr_go;
    logic                  rd_go;
    logic                  arready;
    logic [AXI_DATA_W-1:0] wr_word;
    logic                  bvalid_q;
    axi_resp_e             bresp_q;
    logic                  rvalid_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    axi_resp_e             rresp_q;

    // 32-bit register view of one table entry
    function automatic logic [AXI_DATA_W-1:0] table_word(
        input cfg_table_e  tbl,
        input bucket_cfg_t cfg
    );
        logic [AXI_DATA_W-1:0] word;
        word = '0;
        case (tbl)
            CIR_TABLE:    word[CIR_W-1:0] = cfg.cir;
            CBS_TABLE:    word[CBS_W-1:0] = cfg.cbs;
            ENABLE_TABLE: word[0]         = cfg.enable;
            default:      word            = '0;
        endcase
        return word;
    endfunction

    //////////////////////////////
    // Address decode

    assign wr_table = cfg_table_e'(axil_req.awaddr[TABLE_LSB +: TABLE_W]);
    assign rd_table = cfg_table_e'(axil_req.araddr[TABLE_LSB +: TABLE_W]);
    assign wr_port  = axil_req.awaddr[PORT_LSB +: PORT_W];
    assign rd_port  = axil_req.araddr[PORT_LSB +: PORT_W];

    assign wr_hit = (wr_port < NUM_PORTS) &&
                    (wr_table inside {CIR_TABLE, CBS_TABLE, ENABLE_TABLE});
    assign rd_hit = (rd_port < NUM_PORTS) &&
                    (rd_table inside {CIR_TABLE, CBS_TABLE, ENABLE_TABLE});

    // Keep array lookups in range on a miss
    assign wr_idx = wr_hit ? wr_port : '0;
    assign rd_idx = rd_hit ? rd_port : '0;

    // AW and W are taken together once the B slot is free
    assign wr_go   = axil_req.awvalid & axil_req.wvalid & (~bvalid_q | axil_req.bready);
    assign arready = ~rvalid_q | axil_req.rready;
    assign rd_go   = axil_req.arvalid & arready;

    // Byte strobes merge into the stored value
    always_comb begin
        wr_word = table_word(wr_table, port_cfg[wr_idx]);
        for (int b = 0; b < AXI_STRB_W; b++) begin
            if (axil_req.wstrb[b]) begin
                wr_word[b*8 +: 8] = axil_req.wdata[b*8 +: 8];
            end
        end
    end

    //////////////////////////////
    // Table storage and responses

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            port_cfg <= '{default: '0};
            bvalid_q <= 1'b0;
            bresp_q  <= OKAY;
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            rresp_q  <= OKAY;
        end else begin
            if (wr_go) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_hit ? OKAY : SLVERR;
                if (wr_hit) begin
                    case (wr_table)
                        CIR_TABLE:    port_cfg[wr_idx].cir    <= wr_word[CIR_W-1:0];
                        CBS_TABLE:    port_cfg[wr_idx].cbs    <= wr_word[CBS_W-1:0];
                        ENABLE_TABLE: port_cfg[wr_idx].enable <= wr_word[0];
                        default:      port_cfg[wr_idx]        <= port_cfg[wr_idx];
                    endcase
                end
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_go) begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_hit ? table_word(rd_table, port_cfg[rd_idx]) : '0;
                rresp_q  <= rd_hit ? OKAY : SLVERR;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        axil_rsp.awready = wr_go;
        axil_rsp.wready  = wr_go;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

endmodule

//--- logic/token_bucket_bank.sv
//////////////////////////////
// Token bucket bank
//////////////////////////////

`timescale 1ns/1ps

module token_bucket_bank
    import policer_pkg::*;
(
    input  logic        core_clk_ifc,
    input  logic        timer_reset,
    input  bucket_cfg_t port_cfg [NUM_PORTS],
    input  logic        check_valid,
    input  pkt_desc_t   check_desc,
    output logic        drop_mark
);

    // Levels are 24.8 fixed point bytes
    logic [LEVEL_W-1:0]       level_q   [NUM_PORTS];
    logic [LEVEL_W-1:0]       cir_fixed [NUM_PORTS];
    logic [LEVEL_W-1:0]       drained   [NUM_PORTS];

    logic [PORT_W-1:0]        chk_port;
    logic                     chk_in_range;
    logic [PORT_W-1:0]        chk_idx;
    bucket_cfg_t              chk_cfg;
    logic [LEVEL_W-1:0]       chk_level;
    logic [LEVEL_WHOLE_W:0]   chk_sum;
    logic [LEVEL_W-1:0]       len_fixed;
    logic                     over_cbs;
    logic                     admit;

    //////////////////////////////
    // Per-cycle drain

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            cir_fixed[p] = LEVEL_W'(port_cfg[p].cir);
            // Saturate at an empty bucket
            drained[p] = (level_q[p] > cir_fixed[p]) ? level_q[p] - cir_fixed[p] : '0;
        end
    end

    //////////////////////////////
    // Admit or mark

    assign chk_port     = check_desc.ingress_port;
    assign chk_in_range = (chk_port < NUM_PORTS);
    assign chk_idx      = chk_in_range ? chk_port : '0;
    assign chk_cfg      = port_cfg[chk_idx];
    assign chk_level    = level_q[chk_idx];

    // Only whole bytes of the level take part in the decision
    assign chk_sum  = {1'b0, chk_level[LEVEL_W-1 -: LEVEL_WHOLE_W]}
                    + (LEVEL_WHOLE_W+1)'(check_desc.byte_length);
    assign over_cbs = chk_sum > {1'b0, chk_cfg.cbs};

    assign len_fixed = LEVEL_W'(check_desc.byte_length) << LEVEL_FRAC_W;

    // Out-of-range ports behave as disabled
    assign drop_mark = check_valid & chk_in_range & chk_cfg.enable & over_cbs;
    assign admit     = check_valid & chk_in_range & chk_cfg.enable & ~over_cbs;

    //////////////////////////////
    // Level update

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            level_q <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Accept edge adds the length and drain resumes next cycle
                if (admit && (chk_idx == PORT_W'(p))) begin
                    level_q[p] <= level_q[p] + len_fixed;
                end else begin
                    level_q[p] <= drained[p];
                end
            end
        end
    end

endmodule

//--- logic/policer_marker.sv
//////////////////////////////
// Descriptor marker stage
//////////////////////////////

`timescale 1ns/1ps

module policer_marker
    import policer_pkg::*;
(
    input  logic          core_clk_ifc,
    input  logic          timer_reset,
    input  logic          in_valid,
    output logic          in_ready,
    input  pkt_desc_t     in_desc,
    output logic          check_valid,
    output pkt_desc_t     check_desc,
    input  logic          drop_mark,
    output logic          out_valid,
    input  logic          out_ready,
    output policed_desc_t out_desc
);

    policed_desc_t          entry_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_CNT_W-1:0] count_q;
    logic                   push;
    logic                   pop;

    //////////////////////////////
    // Handshakes

    // Stall only when both entries hold a descriptor
    assign in_ready = (count_q != QUEUE_CNT_W'(QUEUE_DEPTH));
    assign push     = in_valid & in_ready;
    assign pop      = out_valid & out_ready;

    // Bucket sees the descriptor on its accept cycle
    assign check_valid = push;
    assign check_desc  = in_desc;

    assign out_valid = (count_q != '0);
    assign out_desc  = entry_q[rd_ptr_q];

    //////////////////////////////
    // In-order queue

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            entry_q  <= '{default: '0};
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                entry_q[wr_ptr_q].desc              <= in_desc;
                entry_q[wr_ptr_q].policer_drop_mark <= drop_mark;
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- logic/ingress_policer_top.sv
//////////////////////////////
// Ingress policer top
//////////////////////////////

`timescale 1ns/1ps

module ingress_policer_top
    import policer_pkg::*;
(
    input  logic          core_clk_ifc,
    input  logic          timer_reset,
    input  axil_req_t     axil_req,
    output axil_rsp_t     axil_rsp,
    input  logic          in_valid,
    output logic          in_ready,
    input  pkt_desc_t     in_desc,
    output logic          out_valid,
    input  logic          out_ready,
    output policed_desc_t out_desc
);

    bucket_cfg_t port_cfg [NUM_PORTS];
    logic        check_valid;
    pkt_desc_t   check_desc;
    logic        drop_mark;

    // Per-port CIR, CBS and enable tables
    policer_cfg_regs u_cfg_regs (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .port_cfg     (port_cfg)
    );

    token_bucket_bank u_bucket_bank (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .port_cfg     (port_cfg),
        .check_valid  (check_valid),
        .check_desc   (check_desc),
        .drop_mark    (drop_mark)
    );

    // Descriptor path with the two-entry output queue
    policer_marker u_marker (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_desc      (in_desc),
        .check_valid  (check_valid),
        .check_desc   (check_desc),
        .drop_mark    (drop_mark),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_desc     (out_desc)
    );

endmodule

//--- verification/policer_tb_tasks.svh
//////////////////////////////
// Policer testbench tasks
//////////////////////////////

// Register map address with the table in bits 9:8 and the port in bits 5:2
function automatic logic [AXI_ADDR_W-1:0] cfg_addr(input cfg_table_e tbl, input int port);
    return AXI_ADDR_W'((int'(tbl) << 8) | (port << 2));
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

//////////////////////////////
// AXI4-Lite host

task automatic write_reg(
    input  logic [AXI_ADDR_W-1:0] addr,
    input  logic [AXI_DATA_W-1:0] data,
    output axi_resp_e             resp
);
    int port;
    port = int'(addr[5:2]);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    @(posedge core_clk_ifc);
    while (!axil_rsp.awready) @(posedge core_clk_ifc);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    // Model sees the new setting from the cycle after the handshake
    if (port < NUM_PORTS) begin
        case (addr[9:8])
            2'd0:    shadow_cfg[port].cir    = data[15:0];
            2'd1:    shadow_cfg[port].cbs    = data[23:0];
            2'd2:    shadow_cfg[port].enable = data[0];
            default: ;
        endcase
    end
    @(posedge core_clk_ifc);
    while (!axil_rsp.bvalid) @(posedge core_clk_ifc);
    resp = axil_rsp.bresp;
    #1;
    axil_req.bready = 1'b0;
endtask

task automatic read_reg(
    input  logic [AXI_ADDR_W-1:0] addr,
    output logic [AXI_DATA_W-1:0] data,
    output axi_resp_e             resp
);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    @(posedge core_clk_ifc);
    while (!axil_rsp.arready) @(posedge core_clk_ifc);
    #1;
    axil_req.arvalid = 1'b0;
    @(posedge core_clk_ifc);
    while (!axil_rsp.rvalid) @(posedge core_clk_ifc);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    #1;
    axil_req.rready = 1'b0;
endtask

//////////////////////////////
// Descriptor source

// Mode picks a fixed expected mark or the bucket model's
task automatic send_desc(input pkt_desc_t d, input int mode);
    mark_mode = mode;
    in_desc   = d;
    in_valid  = 1'b1;
    @(posedge core_clk_ifc);
    while (!in_ready) @(posedge core_clk_ifc);
    #1;
    in_valid = 1'b0;
endtask

//////////////////////////////
// Reference bucket model

function automatic logic predict_mark(input pkt_desc_t d);
    int     port;
    longint whole;
    port = int'(d.ingress_port);
    if (port >= NUM_PORTS || !shadow_cfg[port].enable) begin
        return 1'b0;
    end
    whole = longint'(model_level[port] >> 8);
    return (whole + longint'(d.byte_length)) > longint'(shadow_cfg[port].cbs);
endfunction

// One clock edge of the model
task automatic step_model();
    int                 p;
    logic               mark;
    logic [LEVEL_W-1:0] cir;
    p    = -1;
    mark = 1'b0;
    if (in_valid && in_ready) begin
        p    = int'(in_desc.ingress_port);
        mark = predict_mark(in_desc);
        expect_q.push_back({in_desc, (mark_mode == MARK_MODEL) ? mark : mark_mode[0]});
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
        cir = LEVEL_W'(shadow_cfg[i].cir);
        if (i == p && shadow_cfg[i].enable && !mark) begin
            model_level[i] = model_level[i] + (LEVEL_W'(in_desc.byte_length) << 8);
        end else begin
            model_level[i] = (model_level[i] > cir) ? model_level[i] - cir : '0;
        end
    end
endtask

//--- verification/policer_tb.sv
//////////////////////////////
// Ingress policer testbench
//////////////////////////////

`timescale 1ns/1ps

module policer_tb
    import policer_pkg::*;
();

    localparam int MARK_CLEAR  = 0;
    localparam int MARK_SET    = 1;
    localparam int MARK_MODEL  = 2;
    localparam int DESC_TOTAL  = 4 * 200 + 3 * NUM_PORTS;
    // Initial drain plus two full drains of 1000 bytes per port at 4 bytes a cycle
    localparam int DRAIN_WAIT  = 1100 + NUM_PORTS * 2 * (1000 * 256 / 1024 + 8);
    localparam int CYCLE_LIMIT = DESC_TOTAL * 4 + DRAIN_WAIT + 2000;

    logic               core_clk_ifc;
    logic               timer_reset;
    axil_req_t          axil_req;
    axil_rsp_t          axil_rsp;
    logic               in_valid;
    logic               in_ready;
    pkt_desc_t          in_desc;
    logic               out_valid;
    logic               out_ready;
    policed_desc_t      out_desc;

    integer             seed;
    integer             ready_seed;
    logic               toggle_ready;
    int                 mark_mode;
    int                 errors;
    int                 checks;
    int                 cycle_count;
    bucket_cfg_t        shadow_cfg [NUM_PORTS];
    logic [LEVEL_W-1:0] model_level [NUM_PORTS];
    policed_desc_t      expect_q [$];

    initial core_clk_ifc = 1'b0;
    always #4 core_clk_ifc = ~core_clk_ifc;

    ingress_policer_top DUT (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_desc      (in_desc),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_desc     (out_desc)
    );

    `include "policer_tb_tasks.svh"

    //////////////////////////////
    // Scoreboard and watchdog

    always @(posedge core_clk_ifc) begin : scoreboard
        policed_desc_t exp;
        if (!timer_reset) begin
            if (out_valid && out_ready) begin
                checks++;
                assert (expect_q.size() != 0) else begin
                    $display("Output descriptor arrived while none was expected");
                    errors++;
                end
                if (expect_q.size() != 0) begin
                    exp = expect_q.pop_front();
                    assert (out_desc == exp) else begin
                        $display("[ERROR] out_desc got %h expected %h", out_desc, exp);
                        errors++;
                    end
                end
            end
            step_model();
        end
    end

    always @(posedge core_clk_ifc) begin
        #1;
        out_ready = toggle_ready ? 1'($random(ready_seed)) : 1'b1;
    end

    always @(posedge core_clk_ifc) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers

    function automatic pkt_desc_t random_desc();
        pkt_desc_t d;
        d.ingress_port = PORT_W'($unsigned($random(seed)) % NUM_PORTS);
        d.egress_port  = PORT_W'($random(seed));
        d.prio         = PRIO_W'($random(seed));
        d.byte_length  = BLEN_W'($unsigned($random(seed)) % 1500 + 1);
        return d;
    endfunction

    task automatic set_port(input int p, input logic [15:0] cir, input logic [23:0] cbs,
                            input logic en);
        axi_resp_e resp;
        write_reg(cfg_addr(CIR_TABLE, p), AXI_DATA_W'(cir), resp);
        check_value("bresp", 32'(resp), 32'(OKAY));
        write_reg(cfg_addr(CBS_TABLE, p), AXI_DATA_W'(cbs), resp);
        check_value("bresp", 32'(resp), 32'(OKAY));
        write_reg(cfg_addr(ENABLE_TABLE, p), AXI_DATA_W'(en), resp);
        check_value("bresp", 32'(resp), 32'(OKAY));
    endtask

    task automatic drain_wait(input int p, input logic [LEVEL_W-1:0] limit);
        while (model_level[p] > limit) begin
            @(posedge core_clk_ifc);
            #1;
        end
    endtask

    task automatic flush_outputs();
        while (expect_q.size() != 0) begin
            @(posedge core_clk_ifc);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("%s finished with %0d errors", name, errors - err0);
    endtask

    //////////////////////////////
    // Tests

    task automatic register_test();
        int                    err0;
        logic [15:0]           cir;
        logic [23:0]           cbs;
        logic                  en;
        logic [AXI_DATA_W-1:0] data;
        axi_resp_e             resp;
        err0 = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cir = 16'($random(seed));
            cbs = 24'($random(seed));
            en  = 1'($random(seed));
            set_port(p, cir, cbs, en);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            read_reg(cfg_addr(CIR_TABLE, p), data, resp);
            check_value("rresp", 32'(resp), 32'(OKAY));
            check_value("rdata", data, 32'(shadow_cfg[p].cir));
            read_reg(cfg_addr(CBS_TABLE, p), data, resp);
            check_value("rresp", 32'(resp), 32'(OKAY));
            check_value("rdata", data, 32'(shadow_cfg[p].cbs));
            read_reg(cfg_addr(ENABLE_TABLE, p), data, resp);
            check_value("rresp", 32'(resp), 32'(OKAY));
            check_value("rdata", data, 32'(shadow_cfg[p].enable));
        end
        // Port 11 lies past the last table entry
        write_reg(cfg_addr(CIR_TABLE, NUM_PORTS), 32'hFFFF, resp);
        check_value("bresp", 32'(resp), 32'(SLVERR));
        read_reg(cfg_addr(CIR_TABLE, NUM_PORTS), data, resp);
        check_value("rresp", 32'(resp), 32'(SLVERR));
        check_value("rdata", data, '0);
        report_test("Register access", err0);
    endtask

    task automatic fixed_mark_test(input string name, input logic [15:0] cir,
                                   input logic [23:0] cbs, input int mode);
        int err0;
        err0 = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_port(p, cir, cbs, 1'b1);
        end
        repeat (200) send_desc(random_desc(), mode);
        flush_outputs();
        for (int p = 0; p < NUM_PORTS; p++) begin
            drain_wait(p, '0);
        end
        report_test(name, err0);
    endtask

    task automatic burst_test();
        int err0;
        err0 = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_port(p, 16'd0, 24'($unsigned($random(seed)) % 4096), 1'b1);
        end
        repeat (200) send_desc(random_desc(), MARK_MODEL);
        flush_outputs();
        report_test("Burst limit", err0);
    endtask

    task automatic rate_test();
        int        err0;
        pkt_desc_t d;
        err0 = errors;
        // At 4 to 7 bytes a cycle one drain step lands between 1 and 8 bytes
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_port(p, 16'(1024 + $unsigned($random(seed)) % 768), 24'd1000, 1'b1);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            d              = random_desc();
            d.ingress_port = PORT_W'(p);
            d.byte_length  = BLEN_W'(1000);
            drain_wait(p, '0);
            send_desc(d, MARK_CLEAR);
            drain_wait(p, 32'd2048);
            send_desc(d, MARK_SET);
            drain_wait(p, '0);
            repeat (3) @(posedge core_clk_ifc);
            #1;
            send_desc(d, MARK_CLEAR);
        end
        flush_outputs();
        report_test("Rate drain", err0);
    endtask

    task automatic backpressure_test();
        int        err0;
        logic      en [NUM_PORTS];
        pkt_desc_t d;
        err0 = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            en[p] = 1'($random(seed));
            set_port(p, 16'd0, 24'd0, en[p]);
        end
        toggle_ready = 1'b1;
        repeat (200) begin
            d = random_desc();
            send_desc(d, en[d.ingress_port] ? MARK_SET : MARK_CLEAR);
        end
        flush_outputs();
        toggle_ready = 1'b0;
        report_test("Disable and back-pressure", err0);
    endtask

    initial begin
        seed         = 92;
        ready_seed   = 92;
        timer_reset  = 1'b1;
        axil_req     = '0;
        in_valid     = 1'b0;
        in_desc      = '0;
        out_ready    = 1'b1;
        toggle_ready = 1'b0;
        mark_mode    = MARK_CLEAR;
        errors       = 0;
        checks       = 0;
        cycle_count  = 0;
        shadow_cfg   = '{default: '0};
        model_level  = '{default: '0};
        repeat (10) @(posedge core_clk_ifc);
        #1;
        timer_reset = 1'b0;

        register_test();
        fixed_mark_test("Mark all", 16'd0, 24'd0, MARK_SET);
        fixed_mark_test("Accept all", 16'hFFFF, 24'hFFFFFF, MARK_CLEAR);
        burst_test();
        rate_test();
        backpressure_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+verification
logic/policer_pkg.sv
logic/policer_cfg_regs.sv
logic/token_bucket_bank.sv
logic/policer_marker.sv
logic/ingress_policer_top.sv
verification/policer_tb.sv
